//--- fdiv_pkg.sv
package fdiv_pkg;

	// float word layout
	localparam int word_w = 32; // float word and core mantissa width
	localparam int exp_w = 8; // biased exponent field
	localparam int frac_w = 23; // stored fraction, hidden one excluded
	localparam int ediff_w = 10; // signed exponent difference with bias
	localparam int cls_w = 2; // operand class code width

	localparam logic [ediff_w-1:0] exp_bias = 10'd127; // single precision bias
	localparam logic [exp_w-1:0] exp_max = 8'd255; // reserved exponent for inf and nan

	// newton-raphson core
	localparam int newton_iters = 3; // reciprocal refinements per divide
	localparam int iter_cnt_w = $clog2(newton_iters + 1); // counts 0..newton_iters
	localparam int seed_w = 8; // seed table entry width
	localparam int seed_idx_w = 4; // divisor bits that index the table

	// credit loops
	localparam int in_credits = 2; // queue depth, upstream starting credits
	localparam int qptr_w = (in_credits > 1) ? $clog2(in_credits) : 1;
	localparam int qcnt_w = $clog2(in_credits + 1); // fill level 0..depth
	localparam int out_credits_max = 3; // downstream credits held at most
	localparam int out_cnt_w = $clog2(out_credits_max + 1);

	// special results
	localparam logic [word_w-1:0] qnan_word = 32'h7fc0_0000; // canonical quiet nan

	// operand classes, denormals fold into zero
	localparam logic [cls_w-1:0] cls_zero = 2'd0;
	localparam logic [cls_w-1:0] cls_norm = 2'd1;
	localparam logic [cls_w-1:0] cls_inf = 2'd2;
	localparam logic [cls_w-1:0] cls_nan = 2'd3;

	// one float word, seen raw or as fields
	typedef union packed {
		logic [word_w-1:0] raw; // whole word as it travels on the ports
		struct packed {
			logic sign; // 1 = negative
			logic [exp_w-1:0] exp; // biased exponent
			logic [frac_w-1:0] frac; // fraction without hidden bit
		} fld;
	} fp_word_u;

endpackage

//--- fdiv_credit_queue.sv
module fdiv_credit_queue (
	input logic clk,
	input logic rst,
	input logic in_valid, // one pair per pulse, sender holds a credit
	input logic [fdiv_pkg::word_w-1:0] dividend,
	input logic [fdiv_pkg::word_w-1:0] divisor,
	output logic in_credit, // one pulse per drained entry
	input logic q_pop, // head consumed by the core
	output logic q_valid, // head entry present
	output logic [fdiv_pkg::word_w-1:0] q_dividend,
	output logic [fdiv_pkg::word_w-1:0] q_divisor,
	input logic out_credit, // downstream frees one slot
	input logic out_spend, // one result sent
	output logic out_avail // at least one output credit held
);

	logic [fdiv_pkg::word_w-1:0] mem_a [fdiv_pkg::in_credits]; // dividend slots
	logic [fdiv_pkg::word_w-1:0] mem_b [fdiv_pkg::in_credits]; // divisor slots
	logic [fdiv_pkg::qptr_w-1:0] head; // oldest entry
	logic [fdiv_pkg::qptr_w-1:0] tail; // next free slot
	logic [fdiv_pkg::qcnt_w-1:0] fill; // entries held
	logic [fdiv_pkg::out_cnt_w-1:0] out_cnt; // downstream credits on hand

	assign q_valid = (fill != '0);
	assign q_dividend = mem_a[head]; // head is read in place
	assign q_divisor = mem_b[head];
	assign out_avail = (out_cnt != '0);

	// slot storage, written at the tail
	always_ff @(posedge clk) begin
		if (in_valid) begin
			mem_a[tail] <= dividend;
			mem_b[tail] <= divisor;
		end
	end

	// pointers, fill level and the returned credit
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			head <= '0;
			tail <= '0;
			fill <= '0;
			in_credit <= 1'b0;
		end else begin
			in_credit <= q_pop; // credit goes back one cycle after the pop
			if (in_valid) begin
				tail <= (tail == fdiv_pkg::in_credits - 1) ? '0 : tail + 1'b1; // wrap
			end
			if (q_pop) begin
				head <= (head == fdiv_pkg::in_credits - 1) ? '0 : head + 1'b1;
			end
			case ({in_valid, q_pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill; // both or neither, level unchanged
			endcase
		end
	end

	// output credit counter
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			out_cnt <= '0; // downstream grants before anything is sent
		end else begin
			case ({out_credit, out_spend})
				2'b10: begin
					if (out_cnt != fdiv_pkg::out_credits_max) begin
						out_cnt <= out_cnt + 1'b1; // saturate at the limit
					end
				end
				2'b01: out_cnt <= out_cnt - 1'b1;
				default: out_cnt <= out_cnt; // grant and spend cancel
			endcase
		end
	end

endmodule

//--- fdiv_unpack.sv
module fdiv_unpack (
	input logic [fdiv_pkg::word_w-1:0] dividend, // raw float a
	input logic [fdiv_pkg::word_w-1:0] divisor, // raw float b
	output logic [fdiv_pkg::word_w-1:0] man_a, // .1xxx form for the core
	output logic [fdiv_pkg::word_w-1:0] man_b,
	output logic [fdiv_pkg::ediff_w-1:0] exp_diff, // ea - eb + bias, signed
	output logic sign, // quotient sign
	output logic [fdiv_pkg::cls_w-1:0] cls_a,
	output logic [fdiv_pkg::cls_w-1:0] cls_b
);

	fdiv_pkg::fp_word_u op_a; // dividend by fields
	fdiv_pkg::fp_word_u op_b; // divisor by fields

	// zero exponent flushes, all-ones splits into inf and nan
	function automatic logic [fdiv_pkg::cls_w-1:0] classify(input fdiv_pkg::fp_word_u w);
		logic [fdiv_pkg::cls_w-1:0] c;
		if (w.fld.exp == '0) begin
			c = fdiv_pkg::cls_zero; // denormal counts as zero
		end else if (w.fld.exp == fdiv_pkg::exp_max) begin
			c = (w.fld.frac != '0) ? fdiv_pkg::cls_nan : fdiv_pkg::cls_inf;
		end else begin
			c = fdiv_pkg::cls_norm;
		end
		return c;
	endfunction

	assign op_a.raw = dividend;
	assign op_b.raw = divisor;

	assign cls_a = classify(op_a);
	assign cls_b = classify(op_b);

	// hidden one on top, fraction below it, zero padding at the bottom
	assign man_a = {1'b1, op_a.fld.frac,
		{(fdiv_pkg::word_w - fdiv_pkg::frac_w - 1){1'b0}}};
	assign man_b = {1'b1, op_b.fld.frac,
		{(fdiv_pkg::word_w - fdiv_pkg::frac_w - 1){1'b0}}};

	// wraps as two's complement, range -126..380 fits
	assign exp_diff = {{(fdiv_pkg::ediff_w - fdiv_pkg::exp_w){1'b0}}, op_a.fld.exp}
		- {{(fdiv_pkg::ediff_w - fdiv_pkg::exp_w){1'b0}}, op_b.fld.exp}
		+ fdiv_pkg::exp_bias;

	assign sign = op_a.fld.sign ^ op_b.fld.sign; // also the sign of inf and zero results

endmodule

//--- newton_div.sv
module newton_div (
	input logic clk,
	input logic rst,
	input logic start, // taken only while idle
	input logic ack, // result consumed, back to idle
	input logic [fdiv_pkg::word_w-1:0] dividend, // .1xxx
	input logic [fdiv_pkg::word_w-1:0] divisor, // .1xxx
	output logic [fdiv_pkg::word_w-1:0] quotient, // x.xxx
	output logic busy, // iterating
	output logic ready // quotient valid until ack
);

	logic [fdiv_pkg::word_w+1:0] reg_x; // reciprocal estimate xx.xxx
	logic [fdiv_pkg::word_w-1:0] reg_a; // dividend .1xxx
	logic [fdiv_pkg::word_w-1:0] reg_b; // divisor .1xxx
	logic [fdiv_pkg::iter_cnt_w-1:0] count; // updates done
	logic [2*fdiv_pkg::word_w+1:0] axi; // a * x, xx.xxx
	logic [2*fdiv_pkg::word_w+1:0] bxi; // b * x, near 1
	logic [fdiv_pkg::word_w+1:0] two_bx; // 2 - b*x as x.xxx
	logic [2*fdiv_pkg::word_w+3:0] x_prod; // x * (2 - b*x), xxx.xxx
	logic [fdiv_pkg::seed_w-1:0] seed; // first estimate fraction
	logic load; // operands captured this edge
	logic step; // one refinement this edge

	// 1/b seed fraction, b in [0.5, 1)
	function automatic logic [fdiv_pkg::seed_w-1:0] seed_lut(
		input logic [fdiv_pkg::seed_idx_w-1:0] idx
	);
		logic [fdiv_pkg::seed_w-1:0] s;
		case (idx)
			4'h0: s = 8'hff;
			4'h1: s = 8'hdf;
			4'h2: s = 8'hc3;
			4'h3: s = 8'haa;
			4'h4: s = 8'h93;
			4'h5: s = 8'h7f;
			4'h6: s = 8'h6d;
			4'h7: s = 8'h5c;
			4'h8: s = 8'h4d;
			4'h9: s = 8'h3f;
			4'ha: s = 8'h33;
			4'hb: s = 8'h27;
			4'hc: s = 8'h1c;
			4'hd: s = 8'h12;
			4'he: s = 8'h08;
			default: s = 8'h00; // b close to 1
		endcase
		return s;
	endfunction

	assign load = start && !busy && !ready;
	assign step = busy && (count != fdiv_pkg::newton_iters);

	always_comb begin
		axi = reg_x * reg_a;
		bxi = reg_x * reg_b;
		two_bx = ~bxi[2*fdiv_pkg::word_w:fdiv_pkg::word_w-1] + 1'b1; // negate, drops the 2
		x_prod = reg_x * two_bx;
		seed = seed_lut(divisor[fdiv_pkg::word_w-2 -: fdiv_pkg::seed_idx_w]); // bits 30..27
	end

	// top bits of a*x, bumped up when any guard bit is set
	assign quotient = axi[2*fdiv_pkg::word_w:fdiv_pkg::word_w+1]
		+ {{(fdiv_pkg::word_w-1){1'b0}}, |axi[fdiv_pkg::word_w:fdiv_pkg::word_w-2]};

	// datapath registers
	always_ff @(posedge clk) begin
		if (load) begin
			reg_a <= dividend;
			reg_b <= divisor;
			reg_x <= {2'b01, seed, {(fdiv_pkg::word_w - fdiv_pkg::seed_w){1'b0}}}; // 01.seed
		end else if (step) begin
			reg_x <= x_prod[2*fdiv_pkg::word_w+2:fdiv_pkg::word_w+1]; // back to xx.xxx
		end
	end

	// idle -> busy -> ready -> idle
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			busy <= 1'b0;
			ready <= 1'b0;
			count <= '0;
		end else if (load) begin
			busy <= 1'b1;
			count <= '0;
		end else if (busy) begin
			if (count == fdiv_pkg::newton_iters) begin
				busy <= 1'b0; // one extra cycle after the last update
				ready <= 1'b1;
			end else begin
				count <= count + 1'b1;
			end
		end else if (ready && ack) begin
			ready <= 1'b0;
		end
	end

endmodule

//--- fdiv_round_pack.sv
module fdiv_round_pack (
	input logic [fdiv_pkg::word_w-1:0] quotient, // core output x.xxx
	input logic [fdiv_pkg::ediff_w-1:0] exp_diff, // biased, signed
	input logic sign,
	input logic [fdiv_pkg::cls_w-1:0] cls_a,
	input logic [fdiv_pkg::cls_w-1:0] cls_b,
	output logic [fdiv_pkg::word_w-1:0] result
);

	fdiv_pkg::fp_word_u res; // built by fields
	logic [fdiv_pkg::frac_w-1:0] frac_t; // truncated fraction
	logic rnd_bit; // first dropped bit
	logic [fdiv_pkg::frac_w:0] frac_r; // carry and rounded fraction
	logic signed [fdiv_pkg::ediff_w-1:0] exp_n; // after normalizing
	logic signed [fdiv_pkg::ediff_w-1:0] exp_r; // after rounding carry
	logic a_zero, a_inf, a_nan;
	logic b_zero, b_inf, b_nan;

	assign a_zero = (cls_a == fdiv_pkg::cls_zero);
	assign a_inf = (cls_a == fdiv_pkg::cls_inf);
	assign a_nan = (cls_a == fdiv_pkg::cls_nan);
	assign b_zero = (cls_b == fdiv_pkg::cls_zero);
	assign b_inf = (cls_b == fdiv_pkg::cls_inf);
	assign b_nan = (cls_b == fdiv_pkg::cls_nan);

	always_comb begin
		// quotient in [1, 2) keeps exponent, below 1 shifts left once
		if (quotient[fdiv_pkg::word_w-1]) begin
			frac_t = quotient[fdiv_pkg::word_w-2 -: fdiv_pkg::frac_w]; // bits 30..8
			rnd_bit = quotient[fdiv_pkg::word_w-2-fdiv_pkg::frac_w];
			exp_n = exp_diff;
		end else begin
			frac_t = quotient[fdiv_pkg::word_w-3 -: fdiv_pkg::frac_w]; // bits 29..7
			rnd_bit = quotient[fdiv_pkg::word_w-3-fdiv_pkg::frac_w];
			exp_n = exp_diff - 1'b1;
		end

		// half-up, carry out means 1.111.. rolled to 10.000..
		frac_r = {1'b0, frac_t} + {{fdiv_pkg::frac_w{1'b0}}, rnd_bit};
		exp_r = exp_n + {{(fdiv_pkg::ediff_w-1){1'b0}}, frac_r[fdiv_pkg::frac_w]};

		res.fld.sign = sign;
		res.fld.exp = exp_r[fdiv_pkg::exp_w-1:0];
		res.fld.frac = frac_r[fdiv_pkg::frac_w-1:0];

		if (a_nan || b_nan || (a_zero && b_zero) || (a_inf && b_inf)) begin
			res.raw = fdiv_pkg::qnan_word; // invalid, sign dropped
		end else if (a_inf || b_zero) begin
			res.fld.exp = fdiv_pkg::exp_max; // signed inf
			res.fld.frac = '0;
		end else if (a_zero || b_inf) begin
			res.fld.exp = '0; // signed zero
			res.fld.frac = '0;
		end else if (exp_r >= $signed({{(fdiv_pkg::ediff_w-fdiv_pkg::exp_w){1'b0}},
				fdiv_pkg::exp_max})) begin
			res.fld.exp = fdiv_pkg::exp_max; // overflow
			res.fld.frac = '0;
		end else if (exp_r <= 0) begin
			res.fld.exp = '0; // underflow flushed
			res.fld.frac = '0;
		end
	end

	assign result = res.raw;

endmodule

//--- fdiv_top.sv
module fdiv_top (
	input logic clk,
	input logic rst,
	input logic in_valid, // operand pair strobe
	input logic [fdiv_pkg::word_w-1:0] dividend,
	input logic [fdiv_pkg::word_w-1:0] divisor,
	output logic in_credit, // returned per pair drained
	input logic out_credit, // downstream slot freed
	output logic out_valid, // one result per pulse
	output logic [fdiv_pkg::word_w-1:0] quotient
);

	logic q_valid, q_pop;
	logic [fdiv_pkg::word_w-1:0] q_dividend, q_divisor; // queue head
	logic out_avail, out_spend;
	logic [fdiv_pkg::word_w-1:0] man_a, man_b; // core operands
	logic [fdiv_pkg::ediff_w-1:0] exp_diff, exp_diff_r;
	logic sign, sign_r;
	logic [fdiv_pkg::cls_w-1:0] cls_a, cls_b, cls_a_r, cls_b_r;
	logic start, ack, busy, ready;
	logic [fdiv_pkg::word_w-1:0] core_q; // raw mantissa quotient
	logic [fdiv_pkg::word_w-1:0] result; // packed float

	assign start = q_valid && !busy && !ready; // core idle, head present
	assign q_pop = start;
	assign ack = ready && out_avail; // send only with a credit
	assign out_spend = ack;

	fdiv_credit_queue u_queue (
		.clk(clk), .rst(rst), .in_valid(in_valid), .dividend(dividend),
		.divisor(divisor), .in_credit(in_credit), .q_pop(q_pop), .q_valid(q_valid),
		.q_dividend(q_dividend), .q_divisor(q_divisor), .out_credit(out_credit),
		.out_spend(out_spend), .out_avail(out_avail)
	);

	fdiv_unpack u_unpack (
		.dividend(q_dividend), .divisor(q_divisor), .man_a(man_a), .man_b(man_b),
		.exp_diff(exp_diff), .sign(sign), .cls_a(cls_a), .cls_b(cls_b)
	);

	newton_div u_core (
		.clk(clk), .rst(rst), .start(start), .ack(ack), .dividend(man_a),
		.divisor(man_b), .quotient(core_q), .busy(busy), .ready(ready)
	);

	fdiv_round_pack u_pack (
		.quotient(core_q), .exp_diff(exp_diff_r), .sign(sign_r), .cls_a(cls_a_r),
		.cls_b(cls_b_r), .result(result)
	);

	// side fields follow the operands into the core, result word held for output
	always_ff @(posedge clk) begin
		if (start) begin
			exp_diff_r <= exp_diff;
			sign_r <= sign;
			cls_a_r <= cls_a;
			cls_b_r <= cls_b;
		end
		if (ack) begin
			quotient <= result;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= ack; // single cycle, core returns to idle
		end
	end

endmodule

//--- tb_fdiv_ref.svh
`ifndef TB_FDIV_REF_SVH
`define TB_FDIV_REF_SVH

// reciprocal seed fractions, row 0 in the top byte
localparam logic [127:0] seed_rom = 128'hff_df_c3_aa_93_7f_6d_5c_4d_3f_33_27_1c_12_08_00;

function automatic logic [1:0] op_class(input fdiv_pkg::fp_word_u w);
	if (w.fld.exp == 8'd0) return fdiv_pkg::cls_zero; // denormals too
	if (w.fld.exp != 8'd255) return fdiv_pkg::cls_norm;
	return (w.fld.frac == '0) ? fdiv_pkg::cls_inf : fdiv_pkg::cls_nan;
endfunction

function automatic fdiv_pkg::fp_word_u fdiv_model(input logic [31:0] a, input logic [31:0] b);
	fdiv_pkg::fp_word_u ua;
	fdiv_pkg::fp_word_u ub;
	fdiv_pkg::fp_word_u r;
	logic [31:0] ma, mb, q; // significands as 0.32, quotient as 1.31
	logic [33:0] x; // reciprocal 2.32
	logic [33:0] t; // 2 - b*x as 1.33
	logic [65:0] ax, bx;
	logic [67:0] xp;
	logic [23:0] fr; // rounded fraction with carry
	logic [1:0] ka, kb;
	int k, ea, eb, e;
	ua.raw = a;
	ub.raw = b;
	ka = op_class(ua);
	kb = op_class(ub);
	ma = {1'b1, ua.fld.frac, 8'h00};
	mb = {1'b1, ub.fld.frac, 8'h00};
	x = {2'b01, seed_rom[127 - 8 * mb[30:27] -: 8], 24'h0};
	for (k = 0; k < fdiv_pkg::newton_iters; k++) begin
		bx = x * mb;
		t = ~bx[64:31] + 34'd1;
		xp = x * t;
		x = xp[66:33];
	end
	ax = x * ma;
	q = ax[64:33] + (ax[32:30] != 3'b000); // guard bits round up
	if (q[31]) fr = {1'b0, q[30:8]} + q[7];
	else fr = {1'b0, q[29:7]} + q[6]; // below one, shift once
	ea = ua.fld.exp;
	eb = ub.fld.exp;
	e = ea - eb + 127;
	if (!q[31]) e = e - 1;
	if (fr[23]) e = e + 1;
	r.fld.sign = ua.fld.sign ^ ub.fld.sign;
	r.fld.exp = e[7:0];
	r.fld.frac = fr[22:0];
	if (ka == fdiv_pkg::cls_nan || kb == fdiv_pkg::cls_nan
			|| (ka == fdiv_pkg::cls_zero && kb == fdiv_pkg::cls_zero)
			|| (ka == fdiv_pkg::cls_inf && kb == fdiv_pkg::cls_inf)) begin
		r.raw = fdiv_pkg::qnan_word;
	end else if (ka == fdiv_pkg::cls_inf || kb == fdiv_pkg::cls_zero || e >= 255) begin
		r.fld.exp = 8'd255;
		r.fld.frac = '0;
	end else if (ka == fdiv_pkg::cls_zero || kb == fdiv_pkg::cls_inf || e <= 0) begin
		r.fld.exp = 8'd0;
		r.fld.frac = '0;
	end
	return r;
endfunction

function automatic real pow2(input int e);
	real p;
	int k;
	p = 1.0;
	for (k = 0; k < e; k++) p = p * 2.0;
	for (k = 0; k > e; k--) p = p / 2.0;
	return p;
endfunction

function automatic real to_real(input fdiv_pkg::fp_word_u w);
	int e;
	e = w.fld.exp;
	return (1.0 + w.fld.frac / 8388608.0) * pow2(e - 127); // sign ignored, ratio only
endfunction

function automatic bit within_ulp(input fdiv_pkg::fp_word_u a, input fdiv_pkg::fp_word_u b,
		input fdiv_pkg::fp_word_u r);
	real diff;
	int er;
	er = r.fld.exp;
	diff = to_real(r) - to_real(a) / to_real(b);
	if (diff < 0.0) diff = -diff;
	return diff <= pow2(er - 150); // one ulp of the result
endfunction

task automatic check_word(input fdiv_pkg::fp_word_u got, input fdiv_pkg::fp_word_u want,
		input string what);
	if (got.raw !== want.raw) begin
		errors++;
		$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got.raw, want.raw);
	end
endtask

task automatic check_count(input int got, input int want, input string what);
	if (got != want) begin
		errors++;
		$display("CHECK FAILED at %0t: %s, got %0d expected %0d", $time, what, got, want);
	end
endtask

`endif

//--- tb_fdiv.sv
module tb_fdiv;

	localparam int n_rand = 200; // random stream length
	localparam int n_ops = 3 + 18 + 12 + 4 + n_rand; // all tests together
	localparam int cycle_limit = 40 * n_ops + 200;

	logic clk;
	logic rst;
	logic in_valid;
	logic [31:0] dividend;
	logic [31:0] divisor;
	logic in_credit;
	logic out_credit;
	logic out_valid;
	logic [31:0] quotient;

	logic [31:0] exp_q [$]; // expected words in send order
	logic [31:0] a_q [$]; // operands kept for the ulp check
	logic [31:0] b_q [$];
	logic [31:0] ra [n_rand];
	logic [31:0] rb [n_rand];
	int credits = 0; // upstream credits on hand
	int credit_pulses = 0;
	int n_sent = 0;
	int n_results = 0;
	int errors = 0;
	int cycles = 0;
	int credit_mode = 0; // 0 counted grants, 1 every cycle, 2 random
	int grant_left = 0;
	int t_sent = 0; // counts at test start
	int t_err = 0;
	bit ulp_on = 1'b0;
	integer seed = 32'hc81fb894;

	`include "tb_fdiv_ref.svh"

	fdiv_top DUT (
		.clk(clk), .rst(rst), .in_valid(in_valid), .dividend(dividend),
		.divisor(divisor), .in_credit(in_credit), .out_credit(out_credit),
		.out_valid(out_valid), .quotient(quotient)
	);

	always begin
		clk = 1'b0;
		#50;
		clk = 1'b1;
		#50;
	end

	// credit returns sampled mid-cycle
	always @(negedge clk) begin
		if (in_credit) begin
			credits++;
			credit_pulses++;
		end
	end

	// downstream slot grants
	initial begin
		out_credit = 1'b0;
		forever begin
			@(posedge clk);
			#10;
			case (credit_mode)
				1: out_credit = 1'b1;
				2: out_credit = $random(seed) & 1;
				default: begin
					out_credit = (grant_left > 0);
					if (grant_left > 0) grant_left--;
				end
			endcase
		end
	end

	always @(negedge clk) begin : compare
		fdiv_pkg::fp_word_u got;
		fdiv_pkg::fp_word_u want;
		fdiv_pkg::fp_word_u op_a;
		fdiv_pkg::fp_word_u op_b;
		if (out_valid) begin
			n_results++; // every pulse, stray ones included
			if (exp_q.size() == 0) begin
				errors++;
				$display("result %h at %0t arrived with no operation outstanding",
					quotient, $time);
			end else begin
				got.raw = quotient;
				want.raw = exp_q.pop_front();
				op_a.raw = a_q.pop_front();
				op_b.raw = b_q.pop_front();
				check_word(got, want, "quotient against model");
				if (ulp_on && !within_ulp(op_a, op_b, got)) begin
					errors++;
					$display("CHECK FAILED at %0t: %h / %h gave %h, more than one ulp off",
						$time, op_a.raw, op_b.raw, got.raw);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout after %0d cycles, %0d of %0d results seen", cycles, n_results, n_sent);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic tick();
		@(posedge clk);
		#10; // inputs move just after the edge
	endtask

	// blocks until a credit is held
	task automatic send_pair(input logic [31:0] a, input logic [31:0] b);
		fdiv_pkg::fp_word_u m;
		while (credits == 0) tick();
		in_valid = 1'b1;
		dividend = a;
		divisor = b;
		credits--;
		n_sent++;
		m = fdiv_model(a, b);
		exp_q.push_back(m.raw);
		a_q.push_back(a);
		b_q.push_back(b);
		tick();
		in_valid = 1'b0;
	endtask

	// special result also checked against its literal value
	task automatic send_known(input logic [31:0] a, input logic [31:0] b, input logic [31:0] lit);
		fdiv_pkg::fp_word_u w;
		w.raw = lit;
		check_word(fdiv_model(a, b), w, "model against special rule");
		send_pair(a, b);
	endtask

	task automatic set_credits(input int mode, input int grants);
		@(negedge clk); // away from the grant process
		credit_mode = mode;
		grant_left = grants;
		tick();
	endtask

	task automatic wait_drain();
		while (n_results < n_sent) tick();
	endtask

	task automatic end_test(input string name);
		wait_drain();
		$display("%s: %0d ops, %0d errors", name, n_sent - t_sent, errors - t_err);
		t_sent = n_sent;
		t_err = errors;
	endtask

	function automatic logic [31:0] rand_normal();
		logic [31:0] r;
		r = $random(seed);
		r[30] = ~r[29]; // exponent 64..191 so never zero or 255
		return r;
	endfunction

	initial begin : main
		int i;
		rst = 1'b0;
		in_valid = 1'b0;
		dividend = '0;
		divisor = '0;
		credits = fdiv_pkg::in_credits;
		repeat (8) @(posedge clk);
		#10;
		rst = 1'b1;
		tick();

		// no output credits so queue and core fill then stall
		for (i = 0; i < 30; i++) begin
			if (credits > 0) send_pair(32'h40490fdb + i, 32'h402df854);
			else tick();
		end
		check_count(n_sent, fdiv_pkg::in_credits + 1, "pairs taken with no output credits");
		check_count(n_results, 0, "results sent with no output credits");
		check_count(credit_pulses, 1, "credits returned while stalled");
		set_credits(0, n_sent);
		wait_drain();
		check_count(credit_pulses, n_results, "credits returned against operations");
		end_test("credit accounting");

		set_credits(1, 0);
		ulp_on = 1'b1;
		send_pair(32'h40400000, 32'h40400000); // 3 / 3
		send_pair(32'h41400000, 32'h40400000); // 12 / 3
		for (i = 0; i < 16; i++) begin
			send_pair(32'h3fc00001 + (i << 5), {9'h07f, i[3:0], 19'h2a5a5}); // seed row i
		end
		end_test("directed normal");
		ulp_on = 1'b0;

		send_known(32'h7fc00000, 32'h3f800000, 32'h7fc00000); // nan / 1
		send_known(32'h3f800000, 32'h7f800001, 32'h7fc00000);
		send_known(32'h7f800000, 32'hff800000, 32'h7fc00000); // inf / inf
		send_known(32'h00000000, 32'h80000000, 32'h7fc00000); // 0 / 0
		send_known(32'hff800000, 32'h40000000, 32'hff800000);
		send_known(32'h40000000, 32'h80000000, 32'hff800000); // 2 / -0
		send_known(32'h80000000, 32'h40000000, 32'h80000000);
		send_known(32'h40000000, 32'h7f800000, 32'h00000000);
		send_known(32'h00400000, 32'h40000000, 32'h00000000); // denormal flushed
		send_known(32'h40000000, 32'h80000001, 32'hff800000);
		send_known(32'h00000001, 32'h00000002, 32'h7fc00000);
		send_known(32'hc0000000, 32'hff800000, 32'h00000000);
		end_test("special operands");

		send_known(32'h7f000000, 32'h3f000000, 32'h7f800000); // 2^128
		send_known(32'hff000000, 32'h3f000000, 32'hff800000);
		send_known(32'h00800000, 32'h40000000, 32'h00000000); // 2^-127
		send_known(32'h80800000, 32'h40000000, 32'h80000000);
		end_test("exponent limits");

		for (i = 0; i < n_rand; i++) begin
			ra[i] = rand_normal();
			rb[i] = rand_normal();
		end
		set_credits(2, 0);
		for (i = 0; i < n_rand; i++) send_pair(ra[i], rb[i]);
		end_test("random stream");
		repeat (10) tick(); // quiet spell longer than the in to out latency
		check_count(n_results, n_sent, "results against pairs sent");

		$display("summary: %0d sent, %0d results, %0d errors", n_sent, n_results, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- flist.f
+incdir+.
fdiv_pkg.sv
fdiv_credit_queue.sv
fdiv_unpack.sv
newton_div.sv
fdiv_round_pack.sv
fdiv_top.sv
tb_fdiv.sv
